// ==== testbench/miner_patterns.txt ====
// midstate H0..H7, tail words 0..2, nonce base, control (13 words per job)
// control bits 7:0 hold the difficulty, bit 8 lets the testbench pick one so cores 0 and 1 miss
6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 01234567 89abcdef 17181920 00000000 00000000
3a1f9c44 7be2d810 c0ffee01 5d3a9b27 e4417c06 92b7f3d5 0a6c1e88 f1d2c3b4 deadbeef 0badf00d 1715a3c2 00001000 00000100
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 11223344 55667788 99aabbcc ddeeff00 cafebabe 31415926 27182818 10000000 000000ff
81a2c3e4 f5061728 394a5b6c 7d8e9fa0 b1c2d3e4 f5a6b7c8 d9e0f1a2 b3c4d5e6 00c0ffee 13579bdf 2468ace0 7ffffff0 00000100
5f4e3d2c 1b0a9988 77665544 33221100 a5a5a5a5 5a5a5a5a 3c3c3c3c c3c3c3c3 fedcba98 76543210 0f0f0f0f 00000020 00000002
2b7e1516 28aed2a6 abf71588 09cf4f3c 243f6a88 85a308d3 13198a2e 03707344 a4093822 299f31d0 082efa98 ec4e6c89 00000100
9e3779b9 7f4a7c15 f39cc060 5cedc834 1082276b f3a6c5e2 85ebca6b c2b2ae35 27d4eb2f 165667b1 d3a2646c ffffff00 00000000
c6a4a793 5e8f2b17 4d3c2b1a 09f8e7d6 a1b2c3d4 e5f60718 293a4b5c 6d7e8f90 11111111 22222222 33333333 00400000 00000004

// ==== list.f ====
+incdir+include
hw/shaPkg.sv
hw/minerPkg.sv
hw/chainSkid.sv
hw/sha256Core.sv
hw/blockStorage.sv
hw/latticeBlock.sv
hw/bcMinerTop.sv
testbench/bcMinerTb.sv

// ==== testbench/bcMinerTb.sv ====
`timescale 1ns/1ps
`include "miner_macros.svh"

module bcMinerTb import minerPkg::*; ();

	localparam int NUM_JOBS = 8;
	localparam int WORDS_PER_JOB = 13;
	localparam int NUM_CORES = `MINER_NUM_CORES;
	localparam int COUNT_BITS = `MINER_COUNT_BITS;
	localparam int DIFF_W = `MINER_DIFF_BITS;
	localparam int TOTAL_NONCES = NUM_CORES << COUNT_BITS;
	// worst case per job is every core scanning its whole partition, plus slack
	localparam int CYCLE_LIMIT = NUM_JOBS * ((1 << COUNT_BITS) * NUM_CORES * 70 + 200) + 8;

	logic clk;
	logic reset_i;
	logic jobValid;
	logic jobReady;
	logic [255:0] jobMidstate;
	logic [0:2][31:0] jobTail;
	logic [31:0] jobNonceBase;
	logic [DIFF_W-1:0] jobDifficulty;
	logic resultValid;
	logic resultReady;
	logic resultSuccess;
	logic [31:0] resultNonce;
	logic [255:0] resultHash;

	logic [31:0] patMem [0:NUM_JOBS*WORDS_PER_JOB-1];
	logic [31:0] roundK [64];
	result_t expQ [$];
	int errors = 0;
	int received = 0;
	// high from job acceptance until its result is taken
	logic searching = 1'b0;
	integer seed = 95268;

	bcMinerTop u_dut (
		.clk(clk),
		.reset_i(reset_i),
		.jobValid_i(jobValid),
		.jobReady_o(jobReady),
		.jobMidstate_i(jobMidstate),
		.jobTail_i(jobTail),
		.jobNonceBase_i(jobNonceBase),
		.jobDifficulty_i(jobDifficulty),
		.resultValid_o(resultValid),
		.resultReady_i(resultReady),
		.resultSuccess_o(resultSuccess),
		.resultNonce_o(resultNonce),
		.resultHash_o(resultHash)
	);

	// **********************************************************************
	// reference model
	// **********************************************************************
	// round keys from the cube roots of the first 64 primes
	task automatic buildRoundConstants();
		int p;
		int found;
		int hi;
		int lo;
		bit isPrime;
		real r;
		real frac;
		found = 0;
		p = 2;
		while (found < 64) begin
			isPrime = 1'b1;
			for (int d = 2; d * d <= p; d++) begin
				if (p % d == 0)
					isPrime = 1'b0;
			end
			if (isPrime) begin
				r = real'(p) ** (1.0 / 3.0);
				// one newton step sharpens the root
				r = r - (r * r * r - real'(p)) / (3.0 * r * r);
				frac = (r - $floor(r)) * 65536.0;
				hi = $rtoi(frac);
				lo = $rtoi((frac - real'(hi)) * 65536.0);
				roundK[found] = {hi[15:0], lo[15:0]};
				found++;
			end
			p++;
		end
	endtask

	function automatic logic [31:0] rotRight(input logic [31:0] x, input int n);
		logic [63:0] twice;
		twice = {x, x} >> n;
		return twice[31:0];
	endfunction

	// one block from the midstate, words laid out as tail, nonce, padding
	function automatic logic [255:0] compressBlock(input logic [255:0] mid,
			input logic [0:2][31:0] tail, input logic [31:0] nonce);
		logic [31:0] w [64];
		logic [31:0] v [8];
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] tmp1;
		logic [31:0] tmp2;
		logic [255:0] res;
		for (int i = 0; i < 3; i++)
			w[i] = tail[i];
		w[3] = nonce;
		w[4] = 32'h80000000;
		for (int i = 5; i < 15; i++)
			w[i] = 32'h0;
		// 80 bytes of header in bits
		w[15] = 32'd640;
		for (int i = 16; i < 64; i++) begin
			s0 = rotRight(w[i-15], 7) ^ rotRight(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = rotRight(w[i-2], 17) ^ rotRight(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = mid[255 - 32*i -: 32];
		for (int i = 0; i < 64; i++) begin
			s1 = rotRight(v[4], 6) ^ rotRight(v[4], 11) ^ rotRight(v[4], 25);
			tmp1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + roundK[i] + w[i];
			s0 = rotRight(v[0], 2) ^ rotRight(v[0], 13) ^ rotRight(v[0], 22);
			tmp2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			v[7] = v[6];
			v[6] = v[5];
			v[5] = v[4];
			v[4] = v[3] + tmp1;
			v[3] = v[2];
			v[2] = v[1];
			v[1] = v[0];
			v[0] = tmp1 + tmp2;
		end
		for (int i = 0; i < 8; i++)
			res[255 - 32*i -: 32] = mid[255 - 32*i -: 32] + v[i];
		return res;
	endfunction

	function automatic int leadingZeros(input logic [255:0] h);
		int n;
		n = 0;
		while (n < 256 && h[255 - n] == 1'b0)
			n++;
		return n;
	endfunction

	// smallest succeeding nonce over all partitions, or an empty result
	task automatic predictResult(input logic [255:0] mid, input logic [0:2][31:0] tail,
			input logic [31:0] base, input logic pick, inout logic [DIFF_W-1:0] diff,
			output result_t want);
		logic [255:0] hashes [TOTAL_NONCES];
		int best;
		int zeros;
		for (int n = 0; n < TOTAL_NONCES; n++)
			hashes[n] = compressBlock(mid, tail, base + 32'(n));
		// difficulty one above the best of cores 0 and 1, so both miss
		if (pick) begin
			best = 0;
			for (int n = 0; n < (2 << COUNT_BITS); n++) begin
				zeros = leadingZeros(hashes[n]);
				if (zeros > best)
					best = zeros;
			end
			diff = (best >= 255) ? '1 : DIFF_W'(best + 1);
		end
		want = '0;
		for (int n = 0; n < TOTAL_NONCES; n++) begin
			if (!want.success && leadingZeros(hashes[n]) >= int'(diff)) begin
				want.success = 1'b1;
				want.nonce = base + 32'(n);
				want.hash = hashes[n];
			end
		end
	endtask

	// **********************************************************************
	// helpers
	// **********************************************************************
	task automatic checkValue(input string name, input logic [255:0] actual,
			input logic [255:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("error %s: got %0h expected %0h", name, actual, expected);
		end
	endtask

	// record layout is midstate, three tail words, nonce base, control
	task automatic readJob(input int j, output logic [255:0] mid,
			output logic [0:2][31:0] tail, output logic [31:0] base,
			output logic [DIFF_W-1:0] diff, output logic pick);
		int at;
		at = j * WORDS_PER_JOB;
		for (int i = 0; i < 8; i++)
			mid[255 - 32*i -: 32] = patMem[at + i];
		for (int i = 0; i < 3; i++)
			tail[i] = patMem[at + 8 + i];
		base = patMem[at + 11];
		diff = patMem[at + 12][DIFF_W-1:0];
		pick = patMem[at + 12][8];
	endtask

	initial begin : clockGen
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// **********************************************************************
	// job driver
	// **********************************************************************
	initial begin : main
		logic [255:0] mid;
		logic [0:2][31:0] tail;
		logic [31:0] base;
		logic [DIFF_W-1:0] diff;
		logic pick;
		result_t want;
		reset_i = 1'b1;
		jobValid = 1'b0;
		jobMidstate = '0;
		jobTail = '0;
		jobNonceBase = '0;
		jobDifficulty = '0;
		resultReady = 1'b0;
		buildRoundConstants();
		$readmemh("testbench/miner_patterns.txt", patMem);
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		checkValue("jobReady_o", jobReady, 1'b1);
		checkValue("resultValid_o", resultValid, 1'b0);

		for (int j = 0; j < NUM_JOBS; j++) begin
			readJob(j, mid, tail, base, diff, pick);
			predictResult(mid, tail, base, pick, diff, want);
			@(posedge clk);
			jobValid <= 1'b1;
			jobMidstate <= mid;
			jobTail <= tail;
			jobNonceBase <= base;
			jobDifficulty <= diff;
			// held valid until the storage frees up
			@(negedge clk);
			while (!jobReady)
				@(negedge clk);
			@(posedge clk);
			searching = 1'b1;
			expQ.push_back(want);
			jobValid <= 1'b0;
		end

		wait (received == NUM_JOBS);
		// a duplicate result would show up in this window
		repeat (20) @(posedge clk);
		$display("errors: %0d, results received: %0d of %0d", errors, received, NUM_JOBS);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// **********************************************************************
	// result receiver
	// **********************************************************************
	initial begin : receiver
		result_t held;
		result_t seen;
		result_t want;
		logic pending;
		logic takeNow;
		pending = 1'b0;
		takeNow = 1'b0;
		wait (reset_i === 1'b0);
		forever begin
			@(posedge clk);
			if (takeNow)
				searching = 1'b0;
			// ready is low about a quarter of the time
			resultReady <= ($random(seed) & 3) != 0;
			@(negedge clk);
			takeNow = resultValid && resultReady;
			seen = '{success: resultSuccess, nonce: resultNonce, hash: resultHash};
			if (resultValid) begin
				// a result not taken last cycle must not move
				if (pending) begin
					checkValue("resultSuccess_o", seen.success, held.success);
					checkValue("resultNonce_o", seen.nonce, held.nonce);
					checkValue("resultHash_o", seen.hash, held.hash);
				end
				held = seen;
				pending = 1'b1;
				if (resultReady) begin
					pending = 1'b0;
					if (expQ.size() == 0) begin
						errors++;
						$display("a result arrived with no job outstanding");
					end else begin
						want = expQ.pop_front();
						checkValue("resultSuccess_o", seen.success, want.success);
						checkValue("resultNonce_o", seen.nonce, want.nonce);
						checkValue("resultHash_o", seen.hash, want.hash);
						received++;
					end
				end
			end else if (pending) begin
				errors++;
				$display("resultValid_o dropped before the result was accepted");
				pending = 1'b0;
			end
		end
	end

	// one job at a time, storage stays closed during a search
	always @(negedge clk) begin
		if (searching)
			checkValue("jobReady_o", jobReady, 1'b0);
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles waiting for a result", CYCLE_LIMIT);
		$display("errors: %0d, results received: %0d of %0d", errors, received, NUM_JOBS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== hw/bcMinerTop.sv ====
`timescale 1ns/1ps
`include "miner_macros.svh"

module bcMinerTop import minerPkg::*; (
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        jobValid_i,
	output logic                        jobReady_o,
	input  logic [255:0]                jobMidstate_i,
	input  logic [0:2][31:0]            jobTail_i,
	input  logic [31:0]                 jobNonceBase_i,
	input  logic [`MINER_DIFF_BITS-1:0] jobDifficulty_i,
	output logic                        resultValid_o,
	input  logic                        resultReady_i,
	output logic                        resultSuccess_o,
	output logic [31:0]                 resultNonce_o,
	output logic [255:0]                resultHash_o
);

	localparam int N = `MINER_NUM_CORES;

	// hop i feeds block i, hop N sits past the last block
	logic    jobValid [0:N];
	logic    jobReady [0:N];
	job_t    jobData  [0:N];
	logic    resValid [0:N];
	logic    resReady [0:N];
	result_t resData  [0:N];

	blockStorage bs (
		.clk, .reset_i,
		.jobValid_i, .jobReady_o,
		.jobMidstate_i, .jobTail_i, .jobNonceBase_i, .jobDifficulty_i,
		.bcastValid_o(jobValid[0]), .bcastReady_i(jobReady[0]), .bcastJob_o(jobData[0]),
		.resultValid_i(resValid[N]), .resultReady_i(resultReady_i)
	);

	// no result enters above block 0, no job leaves the last block
	assign resValid[0] = 1'b0;
	assign resData[0] = '0;
	assign jobReady[N] = 1'b0;

	for (genvar i = 0; i < N; i++) begin : g_lattice
		latticeBlock #(.INDEX(i), .NUM_CORES(N)) lblock (
			.clk, .reset_i,
			.jobValid_i(jobValid[i]), .jobReady_o(jobReady[i]), .jobData_i(jobData[i]),
			.downValid_o(jobValid[i+1]), .downReady_i(jobReady[i+1]),
			.downData_o(jobData[i+1]),
			.upValid_i(resValid[i]), .upReady_o(resReady[i]), .upData_i(resData[i]),
			.resValid_o(resValid[i+1]), .resReady_i(resReady[i+1]),
			.resData_o(resData[i+1])
		);
	end

	assign resReady[N] = resultReady_i;
	assign resultValid_o = resValid[N];
	assign resultSuccess_o = resData[N].success;
	assign resultNonce_o = resData[N].nonce;
	assign resultHash_o = resData[N].hash;

endmodule

// ==== hw/latticeBlock.sv ====
`timescale 1ns/1ps
`include "miner_macros.svh"

module latticeBlock import minerPkg::*; #(
	parameter int INDEX = 0,
	parameter int NUM_CORES = `MINER_NUM_CORES
) (
	input  logic    clk,
	input  logic    reset_i,
	input  logic    jobValid_i,
	output logic    jobReady_o,
	input  job_t    jobData_i,
	output logic    downValid_o,
	input  logic    downReady_i,
	output job_t    downData_o,
	input  logic    upValid_i,
	output logic    upReady_o,
	input  result_t upData_i,
	output logic    resValid_o,
	input  logic    resReady_i,
	output result_t resData_o
);

	localparam int CB = `MINER_COUNT_BITS;
	// first nonce of this core's partition, relative to the base
	localparam logic [31:0] PART_BASE = 32'(INDEX) << CB;

	function automatic logic [8:0] lzCount(input logic [255:0] h);
		logic [8:0] n;
		logic hit;
		n = '0;
		hit = 1'b0;
		for (int i = 255; i >= 0; i--) begin
			if (!hit && !h[i])
				n = n + 1'b1;
			else
				hit = 1'b1;
		end
		return n;
	endfunction

	typedef enum logic [2:0] {LB_IDLE, LB_START, LB_WAIT, LB_CMP, LB_DONE} lbState_t;
	lbState_t state;
	logic [CB-1:0] offset;
	job_t jobReg;
	logic [255:0] hashReg;
	result_t ownRes;
	result_t merged;
	logic [31:0] curNonce;
	logic jobSkidReady;
	logic jobAccept;
	logic upAvail;
	logic resPushValid;
	logic resPushReady;
	logic coreReady;
	logic coreDone;
	logic [255:0] coreHash;
	logic hit;
	logic jobTaken;

	// a job is taken only when the downstream hop can take it too
	assign jobReady_o = (state == LB_IDLE) && jobSkidReady;
	assign jobAccept = jobValid_i && jobReady_o;
	assign curNonce = jobReg.nonceBase + PART_BASE + 32'(offset);
	assign hit = lzCount(hashReg) >= {1'b0, jobReg.difficulty};
	assign resPushValid = (state == LB_DONE) && upAvail;

	// **********************************************************************
	// scan controller
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= LB_IDLE;
			offset <= '0;
		end else begin
			case (state)
				LB_IDLE:
					if (jobAccept) begin
						offset <= '0;
						state <= LB_START;
					end
				LB_START:
					if (coreReady) state <= LB_WAIT;
				LB_WAIT:
					if (coreDone) state <= LB_CMP;
				// stop at the first hit or after the last nonce
				LB_CMP:
					if (hit || offset == '1)
						state <= LB_DONE;
					else begin
						offset <= offset + 1'b1;
						state <= LB_START;
					end
				LB_DONE:
					if (resPushValid && resPushReady) state <= LB_IDLE;
				default:
					state <= LB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (jobAccept)
			jobReg <= jobData_i;
		if (state == LB_WAIT && coreDone)
			hashReg <= coreHash;
		if (state == LB_CMP && hit)
			ownRes <= '{success: 1'b1, nonce: curNonce, hash: hashReg};
		else if (state == LB_CMP && offset == '1)
			ownRes <= '0;
	end

	sha256Core core (
		.clk, .reset_i,
		.start_i(state == LB_START), .startReady_o(coreReady),
		.midstate_i(jobReg.midstate), .tail_i(jobReg.tail), .nonce_i(curNonce),
		.done_o(coreDone), .doneReady_i(state == LB_WAIT), .hash_o(coreHash)
	);

	// job hop, absent in the last block
	if (INDEX < NUM_CORES - 1) begin : g_jobHop
		chainSkid #(.PAYLOAD_T(job_t)) jobSkid (
			.clk, .reset_i,
			.inValid_i(jobValid_i && state == LB_IDLE), .inReady_o(jobSkidReady),
			.inData_i(jobData_i),
			.outValid_o(downValid_o), .outReady_i(downReady_i), .outData_o(downData_o)
		);
	end else begin : g_jobEnd
		assign jobSkidReady = 1'b1;
		assign downValid_o = 1'b0;
		assign downData_o = '0;
	end

	// merge, an upstream hit always has the smaller nonce
	if (INDEX == 0) begin : g_head
		assign upAvail = 1'b1;
		assign upReady_o = 1'b0;
		assign merged = ownRes;
	end else begin : g_link
		assign upAvail = upValid_i;
		assign upReady_o = (state == LB_DONE) && resPushReady;
		assign merged = upData_i.success ? upData_i : ownRes;
	end

	chainSkid #(.PAYLOAD_T(result_t)) resSkid (
		.clk, .reset_i,
		.inValid_i(resPushValid), .inReady_o(resPushReady), .inData_i(merged),
		.outValid_o(resValid_o), .outReady_i(resReady_i), .outData_o(resData_o)
	);

	// tracks a job between intake and the result leaving this block
	always_ff @(posedge clk) begin
		if (reset_i)
			jobTaken <= 1'b0;
		else if (jobAccept)
			jobTaken <= 1'b1;
		else if (resValid_o && resReady_i)
			jobTaken <= 1'b0;
	end

	assert property (@(posedge clk) disable iff (reset_i) resValid_o |-> jobTaken);

endmodule

// ==== hw/blockStorage.sv ====
`timescale 1ns/1ps
`include "miner_macros.svh"

module blockStorage import minerPkg::*; (
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        jobValid_i,
	output logic                        jobReady_o,
	input  logic [255:0]                jobMidstate_i,
	input  logic [0:2][31:0]            jobTail_i,
	input  logic [31:0]                 jobNonceBase_i,
	input  logic [`MINER_DIFF_BITS-1:0] jobDifficulty_i,
	output logic                        bcastValid_o,
	input  logic                        bcastReady_i,
	output job_t                        bcastJob_o,
	input  logic                        resultValid_i,
	input  logic                        resultReady_i
);

	// idle, offering the job to the chain, or waiting for the result
	typedef enum logic [1:0] {BS_IDLE, BS_OFFER, BS_WAIT} bsState_t;
	bsState_t state;

	assign jobReady_o = (state == BS_IDLE);
	assign bcastValid_o = (state == BS_OFFER);

	always_ff @(posedge clk) begin
		if (reset_i)
			state <= BS_IDLE;
		else begin
			case (state)
				BS_IDLE:
					if (jobValid_i) state <= BS_OFFER;
				BS_OFFER:
					if (bcastReady_i) state <= BS_WAIT;
				// free again once the top-level result is taken
				BS_WAIT:
					if (resultValid_i && resultReady_i) state <= BS_IDLE;
				default:
					state <= BS_IDLE;
			endcase
		end
	end

	// hold register, loaded on intake and stable while offered
	always_ff @(posedge clk) begin
		if (jobValid_i && jobReady_o)
			bcastJob_o <= '{midstate: jobMidstate_i, tail: jobTail_i,
				nonceBase: jobNonceBase_i, difficulty: jobDifficulty_i};
	end

endmodule

// ==== hw/sha256Core.sv ====
`timescale 1ns/1ps

module sha256Core import shaPkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             start_i,
	output logic             startReady_o,
	input  hashState_t       midstate_i,
	input  logic [0:2][31:0] tail_i,
	input  logic [31:0]      nonce_i,
	output logic             done_o,
	input  logic             doneReady_i,
	output logic [255:0]     hash_o
);

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	hashState_t midReg;
	hashState_t work;
	// rolling schedule where word 0 feeds the current round
	logic [31:0] sched [16];
	logic [6:0] roundCnt;
	logic busy;
	logic accept;
	logic [31:0] t1;
	logic [31:0] t2;
	logic [31:0] nextW;

	assign startReady_o = !busy && !done_o;
	assign accept = start_i && startReady_o;

	// **********************************************************************
	// one compression round
	// **********************************************************************
	always_comb begin
		// t1 uses e, f, g, h and the round key
		t1 = work[7] + (rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25))
			+ ((work[4] & work[5]) ^ (~work[4] & work[6]))
			+ shaKey[roundCnt[5:0]] + sched[0];
		// t2 uses a, b, c
		t2 = (rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22))
			+ ((work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]));
		// schedule word sixteen places ahead
		nextW = (rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10))
			+ sched[9] + (rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3))
			+ sched[0];
	end

	// control runs 64 rounds and then one cycle for the final addition
	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy <= 1'b0;
			done_o <= 1'b0;
			roundCnt <= '0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				roundCnt <= '0;
			end else if (busy) begin
				if (roundCnt == 7'd64) begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end else
					roundCnt <= roundCnt + 1'b1;
			end
			if (done_o && doneReady_i)
				done_o <= 1'b0;
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (accept) begin
			midReg <= midstate_i;
			work <= midstate_i;
			for (int i = 0; i < 3; i++)
				sched[i] <= tail_i[i];
			sched[3] <= nonce_i;
			for (int i = 0; i < 12; i++)
				sched[4 + i] <= shaPadWords[i];
		end else if (busy && roundCnt != 7'd64) begin
			work <= {t1 + t2, work[0], work[1], work[2],
				work[3] + t1, work[4], work[5], work[6]};
			for (int i = 0; i < 15; i++)
				sched[i] <= sched[i + 1];
			sched[15] <= nextW;
		end else if (busy) begin
			for (int i = 0; i < 8; i++)
				hash_o[255 - 32*i -: 32] <= midReg[i] + work[i];
		end
	end

	// an accepted start blocks new starts and yields done 65 cycles on
	assert property (@(posedge clk) disable iff (reset_i)
		accept |=> (!startReady_o && !done_o) [*65] ##1 done_o);

endmodule

// ==== hw/chainSkid.sv ====
`timescale 1ns/1ps
`include "miner_macros.svh"

module chainSkid #(
	parameter type PAYLOAD_T = logic [31:0]
) (
	input  logic     clk,
	input  logic     reset_i,
	input  logic     inValid_i,
	output logic     inReady_o,
	input  PAYLOAD_T inData_i,
	output logic     outValid_o,
	input  logic     outReady_i,
	output PAYLOAD_T outData_o
);

	localparam int DEPTH = `MINER_SKID_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// entries are payload only
	PAYLOAD_T entries [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// ready comes from occupancy alone, no path back from outReady_i
	assign inReady_o = (count < CNT_W'(DEPTH));
	assign outValid_o = (count != '0);
	assign outData_o = entries[rdPtr];
	assign push = inValid_i && inReady_o;
	assign pop = outValid_o && outReady_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// occupancy tracks push and pop in the same cycle
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entries[wrPtr] <= inData_i;
	end

	// a stalled output keeps both its valid and its data
	assert property (@(posedge clk) disable iff (reset_i)
		outValid_o && !outReady_i |=> outValid_o && $stable(outData_o));

endmodule

// ==== hw/minerPkg.sv ====
`include "miner_macros.svh"

package minerPkg;

	// one search job as it travels down the chain
	typedef struct packed {
		// state after the first header block, H0 in the top bits
		logic [255:0]                midstate;
		// header words that precede the nonce
		logic [0:2][31:0]            tail;
		logic [31:0]                 nonceBase;
		logic [`MINER_DIFF_BITS-1:0] difficulty;
	} job_t;

	// one search outcome as it travels back up the chain
	typedef struct packed {
		logic         success;
		logic [31:0]  nonce;
		// hash with H0 first, big-endian
		logic [255:0] hash;
	} result_t;

endpackage

// ==== hw/shaPkg.sv ====
package shaPkg;

	// working words a..h, element 0 sits in the top bits so H0 comes first
	typedef logic [0:7][31:0] hashState_t;

	// **********************************************************************
	// round constants
	// **********************************************************************
	localparam logic [0:63][31:0] shaKey = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// **********************************************************************
	// block padding, message words 4 to 15
	// **********************************************************************
	// the header tail is 80 bytes, so the length field reads 640 bits
	localparam logic [0:11][31:0] shaPadWords = {
		32'h80000000,
		32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000,
		// 64-bit length, high then low word
		32'h00000000, 32'h00000280
	};

endpackage

// ==== include/miner_macros.svh ====
`ifndef MINER_MACROS_SVH
`define MINER_MACROS_SVH

// number of lattice blocks in the chain
`define MINER_NUM_CORES 4

// log2 of the nonces scanned by one core
`define MINER_COUNT_BITS 3

// difficulty field width, counts leading zero bits
`define MINER_DIFF_BITS 8

// entries held by each chain hop
`define MINER_SKID_DEPTH 2

`endif
